// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int data_w     = 16;
  localparam int ram_aw     = 10;  // page_idx_w + page_ow
  localparam int log_aw     = 11;
  localparam int page_ow    = 6;   // 64-word pages
  localparam int phys_pages = 16;
  localparam int page_idx_w = 4;
  localparam int log_page_w = 5;
  localparam int reg_count  = 8;
  localparam int apb_aw     = 12;

  typedef logic [data_w-1:0] data_t;
  typedef logic [ram_aw-1:0] ram_addr_t;
  typedef logic [log_aw-1:0] log_addr_t;

  typedef enum logic [7:0] {
    op_jmp       = 8'd1,
    op_ram2reg   = 8'd2,
    op_reg2ram   = 8'd3,
    op_num2reg   = 8'd4,
    op_reg_plus  = 8'd5,
    op_reg_minus = 8'd6,
    op_exit      = 8'd17
  } opcode_t;

  typedef enum logic [2:0] {
    st_idle,
    st_fetch_op,
    st_fetch_arg,
    st_decode,
    st_xlat,
    st_mem_read,
    st_mem_write,
    st_halted
  } core_state_t;

  typedef enum logic [1:0] {
    mmu_wait,
    mmu_walk,
    mmu_alloc,
    mmu_done
  } mmu_state_t;

  localparam logic [apb_aw-1:0] apb_ctrl_addr = 12'h800;  // bit 11 set

  localparam int stat_running  = 0;
  localparam int stat_halted   = 1;
  localparam int stat_mmu_full = 2;

endpackage

`default_nettype wire

// File: core/core_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module core_sequencer (
  input  wire                     clka,
  input  wire                     rst,
  input  wire                     start,
  output logic                    running,
  output logic                    halted,
  output logic                    core_wr_en,
  output cpu_pkg::ram_addr_t      core_wr_addr,
  output cpu_pkg::data_t          core_wr_data,
  output logic                    core_rd_en,
  output cpu_pkg::ram_addr_t      core_rd_addr,
  input  wire cpu_pkg::data_t     rd_data,
  output logic                    xlat_req,
  output cpu_pkg::log_addr_t      log_addr,
  input  wire                     xlat_done,
  input  wire cpu_pkg::ram_addr_t phys_addr,
  input  wire                     xlat_fault
);
  import cpu_pkg::*;

  core_state_t                  state;
  log_addr_t                    pc;
  log_addr_t                    next_pc;
  opcode_t                      ir_op;
  logic [$clog2(reg_count)-1:0] ir_reg;   // low bits of the reg byte
  data_t                        ir_arg;
  data_t                        regs [reg_count];
  logic                         rd_valid; // rd_data answers last cycle's read

  assign next_pc = (ir_op == op_jmp) ? ir_arg[log_aw-1:0] : pc;

  always_ff @(posedge clka) begin
    if (!rst) begin
      state      <= st_idle;
      running    <= 1'b0;
      halted     <= 1'b0;
      xlat_req   <= 1'b0;
      core_wr_en <= 1'b0;
      core_rd_en <= 1'b0;
      rd_valid   <= 1'b0;
    end else begin
      core_wr_en <= 1'b0;
      core_rd_en <= 1'b0;
      rd_valid   <= core_rd_en;
      if (start) begin
        pc       <= '0;
        regs     <= '{default: '0};
        running  <= 1'b1;
        halted   <= 1'b0;
        xlat_req <= 1'b1;
        log_addr <= '0;
        state    <= st_fetch_op;
      end else if (xlat_fault) begin  // page pool exhausted
        xlat_req <= 1'b0;
        running  <= 1'b0;
        halted   <= 1'b1;
        state    <= st_halted;
      end else begin
        case (state)
          st_fetch_op, st_fetch_arg: begin
            if (xlat_done) begin
              xlat_req     <= 1'b0;
              core_rd_en   <= 1'b1;
              core_rd_addr <= phys_addr;
            end else if (rd_valid) begin
              pc <= pc + 1'b1;
              if (state == st_fetch_op) begin
                ir_op    <= opcode_t'(rd_data[15:8]);
                ir_reg   <= rd_data[$clog2(reg_count)-1:0];
                log_addr <= pc + 1'b1;
                xlat_req <= 1'b1;
                state    <= st_fetch_arg;
              end else begin
                ir_arg <= rd_data;
                state  <= st_decode;
              end
            end
          end
          st_decode: begin
            pc       <= next_pc;
            log_addr <= next_pc;
            xlat_req <= 1'b1;
            state    <= st_fetch_op;
            case (ir_op)
              op_num2reg:   regs[ir_reg] <= ir_arg;
              op_reg_plus:  regs[ir_reg] <= regs[ir_reg] + ir_arg;
              op_reg_minus: regs[ir_reg] <= regs[ir_reg] - ir_arg;
              op_ram2reg, op_reg2ram: begin
                log_addr <= ir_arg[log_aw-1:0];  // data access goes first
                state    <= st_xlat;
              end
              op_exit: begin
                xlat_req <= 1'b0;
                running  <= 1'b0;
                halted   <= 1'b1;
                state    <= st_halted;
              end
              default: begin  // jmp only moves the pc, unknown ops do nothing
              end
            endcase
          end
          st_xlat: begin
            if (xlat_done) begin
              xlat_req <= 1'b0;
              if (ir_op == op_ram2reg) begin
                core_rd_en   <= 1'b1;
                core_rd_addr <= phys_addr;
                state        <= st_mem_read;
              end else begin
                core_wr_en   <= 1'b1;
                core_wr_addr <= phys_addr;
                core_wr_data <= regs[ir_reg];
                state        <= st_mem_write;
              end
            end
          end
          st_mem_read, st_mem_write: begin
            if (state == st_mem_write || rd_valid) begin
              if (state == st_mem_read) begin
                regs[ir_reg] <= rd_data;
              end
              log_addr <= pc;
              xlat_req <= 1'b1;
              state    <= st_fetch_op;
            end
          end
          default: begin  // idle and halted wait for start
          end
        endcase
      end
    end
  end

  assert property (@(posedge clka) disable iff (!rst) core_wr_en |-> running);

endmodule

`default_nettype wire

// File: hw/apb_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_host_port (
  input  wire                       clka,
  input  wire                       rst,
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire [cpu_pkg::apb_aw-1:0] paddr,
  input  wire cpu_pkg::data_t       pwdata,
  output cpu_pkg::data_t            prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      start,
  input  wire                       running,
  input  wire                       halted,
  input  wire                       mmu_full,
  input  wire                       core_wr_en,
  input  wire cpu_pkg::ram_addr_t   core_wr_addr,
  input  wire cpu_pkg::data_t       core_wr_data,
  input  wire                       core_rd_en,
  input  wire cpu_pkg::ram_addr_t   core_rd_addr,
  output logic                      wr_en,
  output cpu_pkg::ram_addr_t        wr_addr,
  output cpu_pkg::data_t            wr_data,
  output logic                      rd_en,
  output cpu_pkg::ram_addr_t        rd_addr,
  input  wire cpu_pkg::data_t       rd_data
);
  import cpu_pkg::*;

  logic  access;
  logic  ram_sel;
  logic  ctrl_sel;
  logic  ram_err;
  logic  apb_wr;
  logic  apb_rd;
  logic  rd_pend;   // data of last cycle's ram read arrives now
  data_t status;

  assign access   = psel && penable;
  assign ram_sel  = !paddr[apb_aw-1];
  assign ctrl_sel = (paddr == apb_ctrl_addr);
  assign ram_err  = ram_sel && running;  // ram belongs to the core

  assign apb_wr = access && pwrite && ram_sel && !running;
  assign apb_rd = access && !pwrite && ram_sel && !running && !rd_pend;

  always_ff @(posedge clka) begin
    if (!rst) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= apb_rd;
    end
  end

  // only an idle ram read waits
  assign pready  = access && (pwrite || !ram_sel || ram_err || rd_pend);
  assign pslverr = access && (ram_err || (!ram_sel && !ctrl_sel));
  assign start   = access && pwrite && ctrl_sel && pwdata[0];

  always_comb begin
    status                = '0;
    status[stat_running]  = running;
    status[stat_halted]   = halted;
    status[stat_mmu_full] = mmu_full;
  end

  assign prdata = ctrl_sel ? status : rd_data;

  // ram ports follow the core while it runs
  assign wr_en   = running ? core_wr_en   : apb_wr;
  assign wr_addr = running ? core_wr_addr : paddr[ram_aw-1:0];
  assign wr_data = running ? core_wr_data : pwdata;
  assign rd_en   = running ? core_rd_en   : apb_rd;
  assign rd_addr = running ? core_rd_addr : paddr[ram_aw-1:0];

  assert property (@(posedge clka) disable iff (!rst) pready |-> psel && penable);

endmodule

`default_nettype wire

// File: hw/block_ram.sv
`timescale 1ns/1ps
`default_nettype none

module block_ram (
  input  wire                     clka,
  input  wire                     wr_en,
  input  wire cpu_pkg::ram_addr_t wr_addr,
  input  wire cpu_pkg::data_t     wr_data,
  input  wire                     rd_en,
  input  wire cpu_pkg::ram_addr_t rd_addr,
  output cpu_pkg::data_t          rd_data
);
  import cpu_pkg::*;

  data_t mem [2**ram_aw];

  always_ff @(posedge clka) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clka) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];  // valid the cycle after rd_en
    end
  end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  wire                       clka,
  input  wire                       rst,
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire [cpu_pkg::apb_aw-1:0] paddr,
  input  wire cpu_pkg::data_t       pwdata,
  output cpu_pkg::data_t            prdata,
  output logic                      pready,
  output logic                      pslverr
);
  import cpu_pkg::*;

  logic      start;
  logic      running;
  logic      halted;
  logic      mmu_full;
  logic      core_wr_en;
  ram_addr_t core_wr_addr;
  data_t     core_wr_data;
  logic      core_rd_en;
  ram_addr_t core_rd_addr;
  logic      wr_en;
  ram_addr_t wr_addr;
  data_t     wr_data;
  logic      rd_en;
  ram_addr_t rd_addr;
  data_t     rd_data;
  logic      xlat_req;
  log_addr_t log_addr;
  logic      xlat_done;
  ram_addr_t phys_addr;
  logic      xlat_fault;

  apb_host_port u_apb (
    .clka(clka), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .start(start), .running(running), .halted(halted), .mmu_full(mmu_full),
    .core_wr_en(core_wr_en), .core_wr_addr(core_wr_addr), .core_wr_data(core_wr_data),
    .core_rd_en(core_rd_en), .core_rd_addr(core_rd_addr),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  core_sequencer u_core (
    .clka(clka), .rst(rst), .start(start), .running(running), .halted(halted),
    .core_wr_en(core_wr_en), .core_wr_addr(core_wr_addr), .core_wr_data(core_wr_data),
    .core_rd_en(core_rd_en), .core_rd_addr(core_rd_addr), .rd_data(rd_data),
    .xlat_req(xlat_req), .log_addr(log_addr), .xlat_done(xlat_done),
    .phys_addr(phys_addr), .xlat_fault(xlat_fault)
  );

  mmu_translate u_mmu (
    .clka(clka), .rst(rst), .start(start), .xlat_req(xlat_req), .log_addr(log_addr),
    .xlat_done(xlat_done), .phys_addr(phys_addr), .xlat_fault(xlat_fault),
    .mmu_full(mmu_full)
  );

  block_ram u_ram (
    .clka(clka), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
  );

endmodule

`default_nettype wire

// File: mmu/mmu_translate.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_translate (
  input  wire                     clka,
  input  wire                     rst,
  input  wire                     start,
  input  wire                     xlat_req,
  input  wire cpu_pkg::log_addr_t log_addr,
  output logic                    xlat_done,
  output cpu_pkg::ram_addr_t      phys_addr,
  output logic                    xlat_fault,
  output logic                    mmu_full
);
  import cpu_pkg::*;

  mmu_state_t            state;
  logic [page_idx_w-1:0] chain [phys_pages];  // next page in the chain, 0 ends it
  logic [log_page_w-1:0] tag   [phys_pages];  // logical page held there
  logic [page_idx_w:0]   alloc_ptr;           // msb set once the pool is used up
  logic [page_idx_w-1:0] alloc_idx;
  logic [page_idx_w-1:0] cur;                 // also the last page translated
  logic [log_page_w-1:0] last_lpage;
  logic [log_page_w-1:0] lpage;
  logic                  pool_empty;

  assign lpage      = log_addr[log_aw-1:page_ow];
  assign alloc_idx  = alloc_ptr[page_idx_w-1:0];
  assign pool_empty = alloc_ptr[page_idx_w];
  assign xlat_done  = (state == mmu_done);
  assign xlat_fault = (state == mmu_alloc) && pool_empty;
  assign phys_addr  = {cur, log_addr[page_ow-1:0]};

  always_ff @(posedge clka) begin
    if (!rst) begin
      state     <= mmu_wait;
      alloc_ptr <= 'd1;
      mmu_full  <= 1'b0;
    end else if (start) begin
      state      <= mmu_wait;
      alloc_ptr  <= 'd1;  // page 0 is the chain head
      mmu_full   <= 1'b0;
      cur        <= '0;
      last_lpage <= '0;
    end else begin
      case (state)
        mmu_wait: begin
          if (xlat_req) begin
            if (lpage == last_lpage) begin
              state <= mmu_done;  // cur still points at it
            end else begin
              cur   <= '0;
              state <= mmu_walk;
            end
          end
        end
        mmu_walk: begin
          if (tag[cur] == lpage) begin
            state <= mmu_done;
          end else if (chain[cur] == '0) begin
            state <= mmu_alloc;  // tail reached, page not mapped
          end else begin
            cur <= chain[cur];
          end
        end
        mmu_alloc: begin
          if (pool_empty) begin
            mmu_full <= 1'b1;
            state    <= mmu_wait;
          end else begin
            cur       <= alloc_idx;
            alloc_ptr <= alloc_ptr + 1'b1;
            state     <= mmu_done;
          end
        end
        default: begin  // mmu_done
          last_lpage <= lpage;
          state      <= mmu_wait;
        end
      endcase
    end
  end

  // append the new page behind the current tail
  always_ff @(posedge clka) begin
    if (start) begin
      chain[0] <= '0;
      tag[0]   <= '0;
    end else if (state == mmu_alloc && !pool_empty) begin
      chain[cur]       <= alloc_idx;
      chain[alloc_idx] <= '0;
      tag[alloc_idx]   <= lpage;
    end
  end

  assert property (@(posedge clka) disable iff (!rst) xlat_done |-> xlat_req);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f verilog.f \
  -o tb_cpu_sim > build.log 2>&1 \
  && ./obj_dir/tb_cpu_sim > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -qx "TEST PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: tb/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

data_t                 model_mem  [2**ram_aw];       // expected physical ram
data_t                 model_regs [reg_count];
logic [page_idx_w-1:0] page_of    [2**log_page_w];   // logical to physical page
logic                  page_valid [2**log_page_w];
int                    next_page;                     // next free physical page
int unsigned           rand_state;

function automatic data_t xorshift_next();
  rand_state = rand_state ^ (rand_state << 13);
  rand_state = rand_state ^ (rand_state >> 17);
  rand_state = rand_state ^ (rand_state << 5);
  return rand_state[15:0];
endfunction

// pages are handed out in order of first touch
function automatic bit map_page(input log_addr_t la, output ram_addr_t pa);
  logic [log_page_w-1:0] lp;
  lp = la[log_aw-1:page_ow];
  pa = '0;
  if (!page_valid[lp]) begin
    if (next_page >= phys_pages) begin
      return 1'b0;  // pool used up
    end
    page_of[lp]    = page_idx_w'(next_page);
    page_valid[lp] = 1'b1;
    next_page++;
  end
  pa = {page_of[lp], la[page_ow-1:0]};
  return 1'b1;
endfunction

function automatic bit fetch_word(input log_addr_t la, output data_t w);
  ram_addr_t pa;
  w = '0;
  if (!map_page(la, pa)) begin
    return 1'b0;
  end
  w = model_mem[pa];
  return 1'b1;
endfunction

// runs the program in model_mem, returns the expected status word
function automatic data_t ref_run();
  log_addr_t  pc;
  data_t      op_word;
  data_t      arg;
  data_t      status;
  ram_addr_t  pa;
  logic [2:0] r;
  bit         done;
  bit         full;
  bit         ok;
  foreach (page_valid[i]) begin
    page_valid[i] = 1'b0;
  end
  foreach (model_regs[i]) begin
    model_regs[i] = '0;
  end
  page_valid[0] = 1'b1;  // logical page 0 sits in physical page 0
  page_of[0]    = '0;
  next_page     = 1;
  pc            = '0;
  pa            = '0;
  done          = 1'b0;
  full          = 1'b0;
  for (int step = 0; step < 4096 && !done; step++) begin
    ok = fetch_word(pc, op_word);
    arg = '0;
    if (ok) begin
      ok = fetch_word(pc + 11'd1, arg);
    end
    pc = pc + 11'd2;
    r  = op_word[2:0];
    if (ok && (op_word[15:8] == op_ram2reg || op_word[15:8] == op_reg2ram)) begin
      ok = map_page(arg[log_aw-1:0], pa);
    end
    if (!ok) begin
      full = 1'b1;
      done = 1'b1;
    end else begin
      case (op_word[15:8])
        op_jmp:       pc = arg[log_aw-1:0];
        op_ram2reg:   model_regs[r] = model_mem[pa];
        op_reg2ram:   model_mem[pa] = model_regs[r];
        op_num2reg:   model_regs[r] = arg;
        op_reg_plus:  model_regs[r] = model_regs[r] + arg;
        op_reg_minus: model_regs[r] = model_regs[r] - arg;
        op_exit:      done = 1'b1;
        default: begin  // no-op
        end
      endcase
    end
  end
  status                = '0;
  status[stat_running]  = !done;
  status[stat_halted]   = done;
  status[stat_mmu_full] = full;
  return status;
endfunction

`endif

// File: tb/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
  import cpu_pkg::*;

  localparam int clk_period         = 10;
  localparam int n_programs         = 6;  // fill pass plus five programs
  localparam int cycles_per_program = 20000;
  localparam int ram_words          = 2**ram_aw;

  logic              clka;
  logic              rst;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [apb_aw-1:0] paddr;
  data_t             pwdata;
  data_t             prdata;
  logic              pready;
  logic              pslverr;

  data_t prog [$];    // program image, loaded at physical 0
  data_t exp_status;
  int    error_count;
  event  run_done;
  event  check_done;

  `include "cpu_ref_model.svh"

  cpu_top UUT (
    .clka(clka), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial begin
    clka = 1'b0;
    forever begin
      #(clk_period / 2) clka = ~clka;
    end
  end

  initial begin
    #(clk_period * cycles_per_program * n_programs);
    abort_run("timeout: the run did not finish in the allowed time");
  end

  task automatic abort_run(input string reason);
    error_count++;
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%04h, expected 0x%04h", name, got, exp));
    end
  endtask

  task automatic check_status(input data_t got, input data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] prdata status: got 0x%04h, expected 0x%04h", got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_waits(input string name, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // one apb transfer; outputs sampled mid cycle, before the completing edge
  task automatic apb_access(input logic write, input logic [apb_aw-1:0] addr,
                            input data_t wdata, output data_t rdata,
                            output logic err, output int waits);
    @(negedge clka);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clka);
    penable = 1'b1;
    waits   = 0;
    #2;
    while (!pready) begin
      if (waits == 8) begin
        abort_run("APB transfer never completed");
      end
      @(negedge clka);
      #2;
      waits++;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clka);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic add_instr(input opcode_t op, input int r, input data_t arg);
    prog.push_back({op, 5'h15, 3'(r)});  // upper reg byte bits are ignored
    prog.push_back(arg);
  endtask

  task automatic load_and_start();
    data_t st;
    logic  err;
    int    waits;
    foreach (prog[i]) begin
      model_mem[i] = prog[i];
      apb_access(1'b1, apb_aw'(i), prog[i], st, err, waits);
    end
    prog.delete();
    exp_status = ref_run();
    apb_access(1'b1, apb_ctrl_addr, 16'h0001, st, err, waits);
    apb_access(1'b0, apb_ctrl_addr, '0, st, err, waits);
    check_bit("status running", st[stat_running], 1'b1);
  endtask

  task automatic finish_program();
    data_t st;
    logic  err;
    int    waits;
    int    polls;
    polls = 0;
    st    = '0;
    while (!st[stat_halted]) begin
      if (polls == 2000) begin
        abort_run("program did not reach the halted state");
      end
      apb_access(1'b0, apb_ctrl_addr, '0, st, err, waits);
      polls++;
    end
    -> run_done;
    @(check_done);
  endtask

  // compare: status and the whole ram against the model
  initial begin
    data_t rd;
    logic  err;
    int    waits;
    forever begin
      @(run_done);
      apb_access(1'b0, apb_ctrl_addr, '0, rd, err, waits);
      check_status(rd, exp_status);
      check_waits("pready wait on status read", waits, 0);
      for (int a = 0; a < ram_words; a++) begin
        apb_access(1'b0, apb_aw'(a), '0, rd, err, waits);
        check_word($sformatf("prdata at 0x%03h", a), rd, model_mem[a]);
        check_bit("pslverr on ram read", err, 1'b0);
        check_waits("pready wait on ram read", waits, 1);
      end
      -> check_done;
    end
  end

  initial begin
    data_t rd;
    logic  err;
    int    waits;
    rst         = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    error_count = 0;
    rand_state  = 44381;
    repeat (16) @(posedge clka);
    @(negedge clka);
    rst = 1'b1;

    for (int a = 0; a < ram_words; a++) begin  // random fill
      model_mem[a] = xorshift_next();
      apb_access(1'b1, apb_aw'(a), model_mem[a], rd, err, waits);
      check_bit("pslverr on ram write", err, 1'b0);
      check_waits("pready wait on ram write", waits, 0);
    end
    exp_status = '0;
    -> run_done;
    @(check_done);

    for (int i = 0; i < 20; i++) begin  // long enough to write into
      add_instr(op_num2reg, i % reg_count, xorshift_next());
    end
    add_instr(op_exit, 0, '0);
    load_and_start();
    apb_access(1'b1, 12'h3f0, ~model_mem[10'h3f0], rd, err, waits);
    check_bit("pslverr on write while running", err, 1'b1);
    finish_program();

    add_instr(op_num2reg, 1, xorshift_next());
    add_instr(op_reg_plus, 1, xorshift_next());
    add_instr(op_num2reg, 2, xorshift_next());
    add_instr(op_reg_minus, 2, xorshift_next());
    add_instr(op_reg2ram, 1, 16'hf905);  // only the low 11 bits count
    add_instr(op_reg2ram, 2, 16'h0106);
    add_instr(op_reg2ram, 2, 16'h0233);
    add_instr(op_exit, 0, '0);
    load_and_start();
    finish_program();

    add_instr(op_ram2reg, 3, 16'h03c7);  // unmapped page
    add_instr(op_reg_plus, 3, 16'h0001);
    add_instr(op_reg2ram, 3, 16'h0411);
    add_instr(op_exit, 0, '0);
    load_and_start();
    finish_program();

    add_instr(op_num2reg, 0, xorshift_next());
    add_instr(op_jmp, 0, 16'h0006);
    add_instr(op_reg2ram, 0, 16'h0500);  // skipped
    add_instr(op_reg2ram, 0, 16'h0600);
    add_instr(op_exit, 0, '0);
    load_and_start();
    finish_program();

    for (int i = 0; i < reg_count; i++) begin
      add_instr(op_num2reg, i, xorshift_next());
    end
    for (int k = 1; k <= 16; k++) begin  // the 16th new page faults
      add_instr(op_reg2ram, k % reg_count, data_t'(k * 65));
    end
    add_instr(op_exit, 0, '0);
    load_and_start();
    finish_program();

    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tb
common/cpu_pkg.sv
hw/block_ram.sv
hw/apb_host_port.sv
core/core_sequencer.sv
mmu/mmu_translate.sv
hw/cpu_top.sv
tb/tb_cpu.sv
